// ==== hw/rf_pkg.sv ====
// Register file sizing for an RV32I integer core.
// RV32E is not supported, all 32 registers are always present.

package rf_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  localparam int unsigned NumRegs  = 32;
  localparam int unsigned RegAddrW = 5;
  localparam int unsigned RegDataW = 32;

  ////////////////////
  // Write port
  ////////////////////

  // Single write port, 38 bits
  typedef struct packed {
    logic                we;
    logic [RegAddrW-1:0] addr;
    logic [RegDataW-1:0] data;
  } rf_wr_t;

endpackage

// ==== hw/ic_pkg.sv ====
// Instruction cache memory and scrambling definitions.
// Single way only. The key and nonce must have the same width, since
// the keystream is their XOR.

package ic_pkg;

  ////////////////////
  // Geometry
  ////////////////////

  localparam int unsigned IcIndexW   = 6;
  localparam int unsigned IcNumLines = 64;
  localparam int unsigned IcTagW     = 22;
  localparam int unsigned IcLineW    = 64;

  typedef logic [IcTagW-1:0]  tag_t;
  typedef logic [IcLineW-1:0] line_t;

  ////////////////////
  // Scrambling
  ////////////////////

  localparam int unsigned ScrKeyW   = 32;
  localparam int unsigned ScrNonceW = 32;

  typedef struct packed {
    logic [ScrKeyW-1:0]   key;
    logic [ScrNonceW-1:0] nonce;
  } scr_key_t;

  // Power-on key, used until the first exchange completes
  localparam logic [ScrKeyW-1:0]   ScrRstKey   = 32'h9E37_79B9;
  localparam logic [ScrNonceW-1:0] ScrRstNonce = 32'h5A17_C3E1;

  localparam scr_key_t ScrKeyDefault = '{key: ScrRstKey, nonce: ScrRstNonce};

  ////////////////////
  // Bank requests
  ////////////////////

  typedef struct packed {
    logic                req;
    logic                write;
    logic [IcIndexW-1:0] index;
    tag_t                wdata;
  } tag_req_t;

  typedef struct packed {
    logic                req;
    logic                write;
    logic [IcIndexW-1:0] index;
    line_t               wdata;
  } line_req_t;

endpackage

// ==== hw/register_file.sv ====
// Flip-flop register file, two combinational read ports, one write port.
// Writes land at the clock edge and show on the read ports a cycle later.
// x0 is constant zero and ignores writes.
`timescale 1ns/1ps

module register_file (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic [rf_pkg::RegAddrW-1:0]  raddr_a_i,
  input  logic [rf_pkg::RegAddrW-1:0]  raddr_b_i,
  input  rf_pkg::rf_wr_t               wr_i,
  output logic [rf_pkg::RegDataW-1:0]  rdata_a_o,
  output logic [rf_pkg::RegDataW-1:0]  rdata_b_o
);

  logic [rf_pkg::RegDataW-1:0] rf_reg [rf_pkg::NumRegs];
  logic [rf_pkg::NumRegs-1:1]  we_dec;

  // One-hot write select, x0 has no entry
  always_comb begin
    for (int unsigned i = 1; i < rf_pkg::NumRegs; i++) begin
      we_dec[i] = wr_i.we && (wr_i.addr == rf_pkg::RegAddrW'(i));
    end
  end

  ////////////////////
  // Storage
  ////////////////////

  assign rf_reg[0] = '0;

  for (genvar i = 1; i < rf_pkg::NumRegs; i++) begin : gen_regs
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rf_reg[i] <= '0;
      end else if (we_dec[i]) begin
        rf_reg[i] <= wr_i.data;
      end
    end
  end

  ////////////////////
  // Read ports
  ////////////////////

  assign rdata_a_o = rf_reg[raddr_a_i];
  assign rdata_b_o = rf_reg[raddr_b_i];

  // An X address would corrupt an unknown register
  a_waddr_known : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    wr_i.we |-> !$isunknown(wr_i.addr)
  );

endmodule

// ==== hw/scramble_key_ctrl.sv ====
// Fetches a fresh scrambling key over a four-phase req/ack handshake.
// An invalidate pulse is dropped unless both req and ack are low.
// The provider must hold the key steady while ack is high.
`timescale 1ns/1ps

module scramble_key_ctrl (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             inval_i,
  input  logic             ack_i,
  input  ic_pkg::scr_key_t key_i,
  output logic             req_o,
  output logic             key_valid_o,
  output ic_pkg::scr_key_t key_o
);

  logic             req_d, req_q;
  logic             key_valid_d, key_valid_q;
  ic_pkg::scr_key_t key_q;
  logic             start;
  logic             done;

  ////////////////////
  // Handshake
  ////////////////////

  // Ack must have fallen before a new request may start
  assign start = inval_i & ~req_q & ~ack_i;
  assign done  = req_q & ack_i;

  always_comb begin
    req_d = req_q;
    if (done) begin
      req_d = 1'b0;
    end else if (start) begin
      req_d = 1'b1;
    end
  end

  always_comb begin
    key_valid_d = key_valid_q;
    if (done) begin
      key_valid_d = 1'b1;
    end else if (start) begin
      key_valid_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q       <= 1'b0;
      key_valid_q <= 1'b1;
    end else begin
      req_q       <= req_d;
      key_valid_q <= key_valid_d;
    end
  end

  ////////////////////
  // Key and nonce
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q <= ic_pkg::ScrKeyDefault;
    end else if (done) begin
      key_q <= key_i;
    end
  end

  assign req_o       = req_q;
  assign key_valid_o = key_valid_q;
  assign key_o       = key_q;

  // Request holds until the provider answers
  a_req_held : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    req_o && !ack_i |=> req_o
  );

  // No new request while the previous ack is still up
  a_req_rise_ack_low : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(req_o) |-> !$past(ack_i)
  );

endmodule

// ==== hw/scr_ram.sv ====
// Single-port memory bank, payload XORed with a key/index keystream.
// Read data and rvalid follow the request by exactly one cycle.
// No back-pressure. Requests are only legal while the key is valid.
`timescale 1ns/1ps

module scr_ram #(
  parameter type payload_t = ic_pkg::tag_t
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        req_i,
  input  logic                        write_i,
  input  logic [ic_pkg::IcIndexW-1:0] addr_i,
  input  payload_t                    wdata_i,
  input  ic_pkg::scr_key_t            key_i,
  input  logic                        key_valid_i,
  output payload_t                    rdata_o,
  output logic                        rvalid_o
);

  localparam int unsigned Width = $bits(payload_t);

  logic [Width-1:0]          mem [ic_pkg::IcNumLines];
  logic [Width-1:0]          keystream;
  logic [Width-1:0]          wdata_bits;
  logic [Width-1:0]          rdata_q;
  logic                      rvalid_q;
  logic [ic_pkg::ScrKeyW-1:0] key_mix;

  ////////////////////
  // Keystream
  ////////////////////

  assign key_mix = key_i.key ^ key_i.nonce;

  // Key and index each repeated across the payload width
  always_comb begin
    for (int unsigned i = 0; i < Width; i++) begin
      keystream[i] = key_mix[i % ic_pkg::ScrKeyW] ^ addr_i[i % ic_pkg::IcIndexW];
    end
  end

  assign wdata_bits = wdata_i;

  ////////////////////
  // Array
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (req_i && write_i) begin
      mem[addr_i] <= wdata_bits ^ keystream;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !write_i) begin
      rdata_q <= mem[addr_i] ^ keystream;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i & ~write_i;
    end
  end

  assign rdata_o  = rdata_q;
  assign rvalid_o = rvalid_q;

  // Key may be mid-exchange, so the bank must be idle then
  a_req_key_valid : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    req_i |-> key_valid_i
  );

endmodule

// ==== hw/core_storage_top.sv ====
// Storage around the core: register file, key controller, tag and data banks.
// Both banks share the key from the controller without a handshake, as it
// holds steady between exchanges.
`timescale 1ns/1ps

module core_storage_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  // Register file
  input  logic [rf_pkg::RegAddrW-1:0] rf_raddr_a_i,
  input  logic [rf_pkg::RegAddrW-1:0] rf_raddr_b_i,
  input  rf_pkg::rf_wr_t              rf_wr_i,
  output logic [rf_pkg::RegDataW-1:0] rf_rdata_a_o,
  output logic [rf_pkg::RegDataW-1:0] rf_rdata_b_o,

  // Key provider
  input  logic                        ic_inval_i,
  input  logic                        scramble_ack_i,
  input  ic_pkg::scr_key_t            scramble_key_i,
  output logic                        scramble_req_o,
  output logic                        ic_key_valid_o,

  // Cache banks
  input  ic_pkg::tag_req_t            ic_tag_req_i,
  input  ic_pkg::line_req_t           ic_data_req_i,
  output ic_pkg::tag_t                ic_tag_rdata_o,
  output logic                        ic_tag_rvalid_o,
  output ic_pkg::line_t               ic_data_rdata_o,
  output logic                        ic_data_rvalid_o
);

  ic_pkg::scr_key_t scr_key;

  ////////////////////
  // Register file
  ////////////////////

  register_file u_register_file (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .raddr_a_i(rf_raddr_a_i),
    .raddr_b_i(rf_raddr_b_i),
    .wr_i     (rf_wr_i),
    .rdata_a_o(rf_rdata_a_o),
    .rdata_b_o(rf_rdata_b_o)
  );

  ////////////////////
  // Key control
  ////////////////////

  scramble_key_ctrl u_key_ctrl (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .inval_i    (ic_inval_i),
    .ack_i      (scramble_ack_i),
    .key_i      (scramble_key_i),
    .req_o      (scramble_req_o),
    .key_valid_o(ic_key_valid_o),
    .key_o      (scr_key)
  );

  ////////////////////
  // Memory banks
  ////////////////////

  scr_ram #(
    .payload_t(ic_pkg::tag_t)
  ) tag_bank (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (ic_tag_req_i.req),
    .write_i    (ic_tag_req_i.write),
    .addr_i     (ic_tag_req_i.index),
    .wdata_i    (ic_tag_req_i.wdata),
    .key_i      (scr_key),
    .key_valid_i(ic_key_valid_o),
    .rdata_o    (ic_tag_rdata_o),
    .rvalid_o   (ic_tag_rvalid_o)
  );

  scr_ram #(
    .payload_t(ic_pkg::line_t)
  ) data_bank (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (ic_data_req_i.req),
    .write_i    (ic_data_req_i.write),
    .addr_i     (ic_data_req_i.index),
    .wdata_i    (ic_data_req_i.wdata),
    .key_i      (scr_key),
    .key_valid_i(ic_key_valid_o),
    .rdata_o    (ic_data_rdata_o),
    .rvalid_o   (ic_data_rvalid_o)
  );

endmodule

// ==== tb/tb_tests.svh ====
// Directed tests, included inside tb_top.
// Each task starts and ends 1 ns after a rising edge.

task automatic tick();
  @(posedge clk);
  #1;
endtask

// Read ports are combinational, so a short settle is enough
task automatic read_regs(input int a, input int b);
  raddr_a = rf_pkg::RegAddrW'(a);
  raddr_b = rf_pkg::RegAddrW'(b);
  #1;
endtask

task automatic wait_req_fall();
  int n;
  n = 0;
  while (scramble_req && n < HandshakeLimit) begin
    tick();
    n++;
  end
  if (scramble_req) begin
    errors++;
    $display("ERROR: scramble_req_o still high %0d cycles after acknowledge", n);
  end
endtask

// Runs a key exchange and leaves the acknowledge high
task automatic install_key(input ic_pkg::scr_key_t new_key);
  tick();
  inval = 1'b1;
  tick();
  inval = 1'b0;
  check_bit("scramble_req_o", scramble_req, 1'b1);
  check_bit("ic_key_valid_o", key_valid, 1'b0);
  ack      = 1'b1;
  prov_key = new_key;
  wait_req_fall();
  check_bit("ic_key_valid_o", key_valid, 1'b1);
endtask

task automatic reset_values();
  check_bit("scramble_req_o", scramble_req, 1'b0);
  check_bit("ic_key_valid_o", key_valid, 1'b1);
  check_bit("ic_tag_rvalid_o", tag_rvalid, 1'b0);
  check_bit("ic_data_rvalid_o", data_rvalid, 1'b0);
  for (int i = 0; i < rf_pkg::NumRegs; i++) begin
    tick();
    read_regs(i, rf_pkg::NumRegs - 1 - i);
    check_word("rf_rdata_a_o", rdata_a, '0);
    check_word("rf_rdata_b_o", rdata_b, '0);
  end
endtask

task automatic register_file_rw();
  logic [rf_pkg::RegDataW-1:0] model [rf_pkg::NumRegs];
  for (int i = 0; i < rf_pkg::NumRegs; i++) begin
    tick();
    rf_wr = '{we: 1'b1, addr: rf_pkg::RegAddrW'(i), data: $urandom};
    // x0 drops every write
    model[i] = (i == 0) ? '0 : rf_wr.data;
  end
  tick();
  rf_wr = '0;
  for (int i = 0; i < rf_pkg::NumRegs; i++) begin
    tick();
    read_regs(i, (i + 7) % rf_pkg::NumRegs);
    check_word("rf_rdata_a_o", rdata_a, model[i]);
    check_word("rf_rdata_b_o", rdata_b, model[(i + 7) % rf_pkg::NumRegs]);
  end
endtask

task automatic key_handshake();
  install_key('{key: $urandom, nonce: $urandom});
  // Ack still high, so this pulse must be dropped
  inval = 1'b1;
  tick();
  inval = 1'b0;
  check_bit("scramble_req_o", scramble_req, 1'b0);
  check_bit("ic_key_valid_o", key_valid, 1'b1);
  tick();
  ack = 1'b0;
endtask

task automatic tag_bank_rw();
  ic_pkg::tag_t                tags [NumTags];
  logic [ic_pkg::IcIndexW-1:0] idx  [NumTags];
  for (int i = 0; i < NumTags; i++) begin
    tags[i] = ic_pkg::tag_t'($urandom);
    idx[i]  = ic_pkg::IcIndexW'(i * 7 + 3);
    tick();
    tag_req = '{req: 1'b1, write: 1'b1, index: idx[i], wdata: tags[i]};
  end
  tick();
  tag_req = '0;
  for (int i = 0; i < NumTags; i++) begin
    tick();
    check_bit("ic_tag_rvalid_o", tag_rvalid, 1'b0);
    tag_req = '{req: 1'b1, write: 1'b0, index: idx[i], wdata: '0};
    tick();
    tag_req = '0;
    check_bit("ic_tag_rvalid_o", tag_rvalid, 1'b1);
    check_tag("ic_tag_rdata_o", tag_rdata, tags[i]);
  end
endtask

// Writes a run of lines, then reads them back one per cycle
task automatic line_round(input int base);
  ic_pkg::line_t lines [LineCount];
  for (int i = 0; i < LineCount; i++) begin
    lines[i] = {$urandom, $urandom};
    tick();
    data_req = '{req: 1'b1, write: 1'b1, index: ic_pkg::IcIndexW'(base + i), wdata: lines[i]};
  end
  for (int i = 0; i < LineCount; i++) begin
    tick();
    data_req = '{req: 1'b1, write: 1'b0, index: ic_pkg::IcIndexW'(base + i), wdata: '0};
    check_bit("ic_data_rvalid_o", data_rvalid, i > 0);
    if (i > 0) begin
      check_line("ic_data_rdata_o", data_rdata, lines[i-1]);
    end
  end
  tick();
  data_req = '0;
  check_bit("ic_data_rvalid_o", data_rvalid, 1'b1);
  check_line("ic_data_rdata_o", data_rdata, lines[LineCount-1]);
  tick();
  check_bit("ic_data_rvalid_o", data_rvalid, 1'b0);
endtask

task automatic data_bank_stream();
  line_round(0);
  install_key('{key: $urandom, nonce: $urandom});
  tick();
  ack = 1'b0;
  line_round(20);
endtask

// ==== tb/tb_top.sv ====
// Directed testbench for core_storage_top.
// Inputs change 1 ns after the rising edge. Outputs are sampled at that point,
// once the registered values have settled.
`timescale 1ns/1ps

module tb_top;

  localparam int ClkPeriod      = 10;
  localparam int ResetCycles    = 8;
  localparam int HandshakeLimit = 16;
  localparam int NumTags        = 8;
  localparam int LineCount      = 6;
  // Cycle count of all tests, with the handshake waits at their limit
  localparam int TestCycles = 3 * rf_pkg::NumRegs + 2 * (HandshakeLimit + 6)
                            + 3 * NumTags + 1 + 2 * (2 * LineCount + 4);
  localparam int TimeoutNs  = (ResetCycles + TestCycles + 200) * ClkPeriod;

  logic                        clk = 1'b0;
  logic                        rst_n;
  logic [rf_pkg::RegAddrW-1:0] raddr_a;
  logic [rf_pkg::RegAddrW-1:0] raddr_b;
  rf_pkg::rf_wr_t              rf_wr;
  logic [rf_pkg::RegDataW-1:0] rdata_a;
  logic [rf_pkg::RegDataW-1:0] rdata_b;
  logic                        inval;
  logic                        ack;
  ic_pkg::scr_key_t            prov_key;
  logic                        scramble_req;
  logic                        key_valid;
  ic_pkg::tag_req_t            tag_req;
  ic_pkg::line_req_t           data_req;
  ic_pkg::tag_t                tag_rdata;
  logic                        tag_rvalid;
  ic_pkg::line_t               data_rdata;
  logic                        data_rvalid;

  int checks;
  int errors;

  core_storage_top dut (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .rf_raddr_a_i    (raddr_a),
    .rf_raddr_b_i    (raddr_b),
    .rf_wr_i         (rf_wr),
    .rf_rdata_a_o    (rdata_a),
    .rf_rdata_b_o    (rdata_b),
    .ic_inval_i      (inval),
    .scramble_ack_i  (ack),
    .scramble_key_i  (prov_key),
    .scramble_req_o  (scramble_req),
    .ic_key_valid_o  (key_valid),
    .ic_tag_req_i    (tag_req),
    .ic_data_req_i   (data_req),
    .ic_tag_rdata_o  (tag_rdata),
    .ic_tag_rvalid_o (tag_rvalid),
    .ic_data_rdata_o (data_rdata),
    .ic_data_rvalid_o(data_rvalid)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_word(input string name, input logic [rf_pkg::RegDataW-1:0] got,
                            input logic [rf_pkg::RegDataW-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_tag(input string name, input ic_pkg::tag_t got, input ic_pkg::tag_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_line(input string name, input ic_pkg::line_t got,
                            input ic_pkg::line_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  `include "tb_tests.svh"

  ////////////////////
  // Watchdog
  ////////////////////

  initial begin
    #(TimeoutNs);
    $display("Timeout: simulation still running after %0d ns", TimeoutNs);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    void'($urandom(63));
    checks   = 0;
    errors   = 0;
    rst_n    = 1'b0;
    raddr_a  = '0;
    raddr_b  = '0;
    rf_wr    = '0;
    inval    = 1'b0;
    ack      = 1'b0;
    prov_key = '0;
    tag_req  = '0;
    data_req = '0;
    repeat (ResetCycles) @(posedge clk);
    #1 rst_n = 1'b1;

    reset_values();
    register_file_rw();
    key_handshake();
    tag_bank_rw();
    data_bank_stream();

    tick();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+tb
hw/rf_pkg.sv
hw/ic_pkg.sv
hw/register_file.sv
hw/scramble_key_ctrl.sv
hw/scr_ram.sv
hw/core_storage_top.sv
tb/tb_top.sv

// ==== Makefile ====
# Verilator build and run of the core storage testbench.
# Override any variable on the command line, e.g. make run LOG=out.log

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST)) tb/tb_tests.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -qx "TEST OK" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
